//--- rtl/bt_bridge.sv
// sensor to HC-05 bridge on a single clock. resetn is a real port and not a trigger bit
module bt_bridge (
	input  logic            clock,
	input  logic            resetn,
	input  logic            bt_state,
	input  logic            rxd,
	input  bt_pkg::word_t   wire_in,
	input  bt_pkg::word_t   trig_in,
	output logic            bt_enable,
	output logic            txd,
	output bt_pkg::status_t status_out,
	output bt_pkg::word_t   response_out
);
	bt_pkg::word_t sensor_word;
	bt_pkg::sel_t sensor_select;
	logic sensor_take;
	bt_pkg::word_t tx_din;
	bt_pkg::word_t tx_head;
	logic tx_push;
	logic tx_take; // pops the head as a word starts
	logic tx_full;
	logic tx_empty;
	logic tx_busy;
	logic send;
	bt_pkg::word_t rx_word;
	logic rx_valid;
	logic rx_push;
	logic resp_pop;
	logic resp_empty;

	test_sensor sensor (.clock(clock), .resetn(resetn), .select(sensor_select),
		.take(sensor_take), .sensor_word(sensor_word));

	word_fifo tx_fifo (.clock(clock), .resetn(resetn), .push(tx_push), .din(tx_din),
		.pop(tx_take), .dout(tx_head), .full(tx_full), .empty(tx_empty));

	word_fifo resp_fifo (.clock(clock), .resetn(resetn), .push(rx_push), .din(rx_word),
		.pop(resp_pop), .dout(response_out), .full(), .empty(resp_empty));

	serial_tx16 tx (.clock(clock), .resetn(resetn), .send(send), .data(tx_head),
		.take(tx_take), .busy(tx_busy), .txd(txd));

	serial_rx16 rx (.clock(clock), .resetn(resetn), .rxd(rxd), .word(rx_word),
		.word_valid(rx_valid));

	link_sequencer seq (.clock(clock), .resetn(resetn), .trig_in(trig_in), .bt_state(bt_state),
		.sensor_word(sensor_word), .wire_in(wire_in), .tx_full(tx_full), .tx_empty(tx_empty),
		.tx_busy(tx_busy), .rx_word(rx_word), .rx_valid(rx_valid), .resp_empty(resp_empty),
		.sensor_take(sensor_take), .sensor_select(sensor_select), .tx_push(tx_push),
		.tx_din(tx_din), .send(send), .rx_push(rx_push), .resp_pop(resp_pop),
		.bt_enable(bt_enable), .status_out(status_out));
endmodule

//--- rtl/bt_pkg.sv
// shared widths and constants for the bridge. CLKS_PER_BIT is a simulation value and FIFO_DEPTH must be a power of two
package bt_pkg;
	localparam int WORD_W = 16;
	localparam int BYTE_W = 8;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [BYTE_W-1:0] byte_t;
	typedef logic [15:0] status_t; // see link_sequencer for the bit layout
	typedef logic [1:0] sel_t;

	// ########################################
	// UART timing
	localparam int CLKS_PER_BIT = 4;
	localparam int CLK_CNT_W = $clog2(CLKS_PER_BIT + 1);
	localparam logic [CLK_CNT_W-1:0] BIT_LAST = CLK_CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [CLK_CNT_W-1:0] HALF_BIT = CLK_CNT_W'(CLKS_PER_BIT / 2 - 1);
	localparam int FRAME_BITS = 2 * (BYTE_W + 2); // two bytes with start and stop
	localparam int BIT_CNT_W = $clog2(FRAME_BITS);
	localparam logic [BIT_CNT_W-1:0] FRAME_LAST = BIT_CNT_W'(FRAME_BITS - 1);

	// ########################################
	// FIFOs, AT protocol, trigger map
	localparam int FIFO_DEPTH = 16;
	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam logic [PTR_W:0] FIFO_FULL = (PTR_W + 1)'(FIFO_DEPTH);
	localparam word_t AT_END = 16'h0D0A; // CR LF

	localparam int TRG_WANT_AT = 1;
	localparam int TRG_USER_READY = 2;
	localparam int TRG_SELECT_LO = 3; // select in bits 4..3
	localparam int TRG_WORD_STROBE = 5;
	localparam int TRG_POP = 6;

	localparam word_t SENSOR_CONST_A = 16'h1234;
	localparam word_t SENSOR_CONST_B = 16'hA5A5;

	typedef enum logic [2:0] {
		IDLE = 3'd0,
		LOAD = 3'd1,
		TRANSMIT = 3'd2,
		RECEIVE = 3'd3,
		COMPLETE = 3'd4
	} seq_state_t;
endpackage

//--- rtl/link_sequencer.sv
// trigger decode and mode FSM. the host must hold user_ready and want_at steady during a run
module link_sequencer (
	input  logic            clock,
	input  logic            resetn,
	input  bt_pkg::word_t   trig_in,
	input  logic            bt_state,
	input  bt_pkg::word_t   sensor_word,
	input  bt_pkg::word_t   wire_in,
	input  logic            tx_full,
	input  logic            tx_empty,
	input  logic            tx_busy,
	input  bt_pkg::word_t   rx_word,
	input  logic            rx_valid,
	input  logic            resp_empty,
	output logic            sensor_take,
	output bt_pkg::sel_t    sensor_select,
	output logic            tx_push,
	output bt_pkg::word_t   tx_din,
	output logic            send,
	output logic            rx_push,
	output logic            resp_pop,
	output logic            bt_enable,
	output bt_pkg::status_t status_out
);
	bt_pkg::seq_state_t state;
	bt_pkg::seq_state_t state_next;
	logic want_at;
	logic user_ready;
	logic word_strobe;
	logic pop_req;
	logic at_mode; // mode taken when leaving IDLE
	logic tx_done;
	logic rx_done;
	logic load_done;
	logic tx_finished;
	logic rx_end;

	// trigger decode
	assign want_at = trig_in[bt_pkg::TRG_WANT_AT];
	assign user_ready = trig_in[bt_pkg::TRG_USER_READY];
	assign word_strobe = trig_in[bt_pkg::TRG_WORD_STROBE];
	assign pop_req = trig_in[bt_pkg::TRG_POP];
	assign sensor_select = trig_in[bt_pkg::TRG_SELECT_LO +: 2];
	assign bt_enable = want_at;

	assign tx_din = at_mode ? wire_in : sensor_word;
	assign tx_push = (state == bt_pkg::LOAD) && (at_mode ? word_strobe : !tx_full);
	assign sensor_take = tx_push && !at_mode;
	assign send = (state == bt_pkg::TRANSMIT) && !tx_empty;
	assign rx_push = (state == bt_pkg::RECEIVE) && rx_valid; // dropped by the FIFO when full
	assign resp_pop = pop_req && !resp_empty;

	assign load_done = at_mode ? (word_strobe && wire_in == bt_pkg::AT_END) : tx_full;
	assign tx_finished = tx_empty && !tx_busy;
	assign rx_end = rx_valid && (rx_word == bt_pkg::AT_END);

	assign status_out = {9'b0, resp_empty, state, rx_done, tx_done, bt_state};

	always_comb
	begin
		state_next = state;
		case (state)
			bt_pkg::IDLE:
				if (user_ready)
					state_next = bt_pkg::LOAD;
			bt_pkg::LOAD:
				if (load_done)
					state_next = bt_pkg::TRANSMIT;
			bt_pkg::TRANSMIT:
				if (tx_finished)
					state_next = at_mode ? bt_pkg::RECEIVE : bt_pkg::COMPLETE;
			bt_pkg::RECEIVE:
				if (rx_end)
					state_next = bt_pkg::COMPLETE;
			bt_pkg::COMPLETE:
				if (!user_ready)
					state_next = bt_pkg::IDLE;
			default:
				state_next = bt_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			state <= bt_pkg::IDLE;
			at_mode <= 1'b0;
			tx_done <= 1'b0;
			rx_done <= 1'b0;
		end
		else
		begin
			state <= state_next;
			if (state == bt_pkg::IDLE)
			begin
				at_mode <= want_at;
				tx_done <= 1'b0; // sticky flags clear only here
				rx_done <= 1'b0;
			end
			if (state == bt_pkg::TRANSMIT && tx_finished)
				tx_done <= 1'b1;
			if (state == bt_pkg::RECEIVE && rx_end)
				rx_done <= 1'b1;
		end
	end

	// host levels stay put from LOAD until the reply is in
	a_run_steady: assert property (@(posedge clock) disable iff (!resetn)
		(state == bt_pkg::LOAD || state == bt_pkg::TRANSMIT || state == bt_pkg::RECEIVE)
		|-> (user_ready && want_at == at_mode))
		else $error("link_sequencer: user_ready or want_at changed during a run");
endmodule

//--- rtl/serial_rx16.sv
// 8N1 receiver pairing bytes into words low byte first. a bad stop bit discards the pending pair
module serial_rx16 (
	input  logic          clock,
	input  logic          resetn,
	input  logic          rxd,
	output bt_pkg::word_t word,
	output logic          word_valid
);
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t state;
	logic rxd_meta;
	logic rxd_s;
	logic [bt_pkg::CLK_CNT_W-1:0] clk_cnt;
	logic [2:0] bit_idx;
	bt_pkg::byte_t shift;
	bt_pkg::byte_t low_byte;
	logic have_low; // low byte waiting for its partner
	logic bit_end;
	logic sample_bit;
	logic stop_ok;

	assign bit_end = (clk_cnt == bt_pkg::BIT_LAST);
	assign sample_bit = (state == RX_DATA) && bit_end;
	assign stop_ok = (state == RX_STOP) && bit_end && rxd_s;

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			rxd_meta <= 1'b1;
			rxd_s <= 1'b1;
		end
		else
		begin
			rxd_meta <= rxd;
			rxd_s <= rxd_meta;
		end
	end

	// ########################################
	// data path
	always_ff @(posedge clock)
	begin
		if (sample_bit)
			shift <= {rxd_s, shift[bt_pkg::BYTE_W-1:1]}; // LSB first
		if (stop_ok && !have_low)
			low_byte <= shift;
		if (stop_ok && have_low)
			word <= {shift, low_byte};
	end

	// ########################################
	// bit timing FSM
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			state <= RX_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			have_low <= 1'b0;
			word_valid <= 1'b0;
		end
		else
		begin
			word_valid <= 1'b0;
			case (state)
				RX_IDLE:
				begin
					clk_cnt <= '0;
					if (!rxd_s)
						state <= RX_START;
				end
				RX_START:
				begin
					if (clk_cnt == bt_pkg::HALF_BIT)
					begin
						clk_cnt <= '0;
						bit_idx <= '0;
						state <= rxd_s ? RX_IDLE : RX_DATA; // glitch goes back to idle
					end
					else
						clk_cnt <= clk_cnt + 1'b1;
				end
				RX_DATA:
				begin
					if (bit_end)
					begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end
					else
						clk_cnt <= clk_cnt + 1'b1;
				end
				default:
				begin
					if (bit_end)
					begin
						state <= RX_IDLE;
						have_low <= rxd_s && !have_low;
						word_valid <= rxd_s && have_low;
					end
					else
						clk_cnt <= clk_cnt + 1'b1;
				end
			endcase
		end
	end
endmodule

//--- rtl/serial_tx16.sv
// 8N1 transmitter for one word as two bytes low byte first. no parity and a fixed bit rate
module serial_tx16 (
	input  logic          clock,
	input  logic          resetn,
	input  logic          send,
	input  bt_pkg::word_t data,
	output logic          take,
	output logic          busy,
	output logic          txd
);
	logic [bt_pkg::FRAME_BITS-1:0] frame; // bit 0 is on the line
	logic [bt_pkg::CLK_CNT_W-1:0] clk_cnt;
	logic [bt_pkg::BIT_CNT_W-1:0] bit_cnt;
	logic active;
	logic bit_end;
	logic frame_end;

	assign bit_end = (clk_cnt == bt_pkg::BIT_LAST);
	assign frame_end = bit_end && (bit_cnt == bt_pkg::FRAME_LAST);

	// next word starts in the last cycle of the high stop bit, no idle gap
	assign take = send && (!active || frame_end);
	assign busy = active;
	assign txd = active ? frame[0] : 1'b1; // line idles high

	always_ff @(posedge clock)
	begin
		if (take)
			frame <= {1'b1, data[15:8], 1'b0, 1'b1, data[7:0], 1'b0};
		else if (active && bit_end)
			frame <= {1'b1, frame[bt_pkg::FRAME_BITS-1:1]};
	end

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			active <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= '0;
		end
		else if (take)
		begin
			active <= 1'b1;
			clk_cnt <= '0;
			bit_cnt <= '0;
		end
		else if (active)
		begin
			if (bit_end)
			begin
				clk_cnt <= '0;
				if (frame_end)
					active <= 1'b0;
				else
					bit_cnt <= bit_cnt + 1'b1;
			end
			else
				clk_cnt <= clk_cnt + 1'b1;
		end
	end
endmodule

//--- rtl/test_sensor.sv
// stand-in for the real sensor with no acquisition timing and a ramp that only moves on take
module test_sensor (
	input  logic          clock,
	input  logic          resetn,
	input  bt_pkg::sel_t  select,
	input  logic          take,
	output bt_pkg::word_t sensor_word
);
	bt_pkg::word_t ramp;

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			ramp <= '0;
		else if (take)
			ramp <= ramp + 1'b1; // next sample after each take
	end

	// pattern mux
	always_comb
	begin
		case (select)
			2'd0: sensor_word = ramp;
			2'd1: sensor_word = bt_pkg::SENSOR_CONST_A;
			2'd2: sensor_word = bt_pkg::SENSOR_CONST_B;
			default: sensor_word = ~ramp; // inverted ramp
		endcase
	end
endmodule

//--- rtl/word_fifo.sv
// single clock word FIFO that ignores push when full and pop when empty
module word_fifo (
	input  logic          clock,
	input  logic          resetn,
	input  logic          push,
	input  bt_pkg::word_t din,
	input  logic          pop,
	output bt_pkg::word_t dout,
	output logic          full,
	output logic          empty
);
	bt_pkg::word_t mem [bt_pkg::FIFO_DEPTH];
	logic [bt_pkg::PTR_W-1:0] wr_ptr;
	logic [bt_pkg::PTR_W-1:0] rd_ptr;
	logic [bt_pkg::PTR_W:0] count;
	logic [bt_pkg::PTR_W:0] count_next;
	logic do_push;
	logic do_pop;

	assign do_push = push && !full;
	assign do_pop = pop && !empty;
	assign dout = mem[rd_ptr]; // head word

	always_comb
	begin
		count_next = count;
		if (do_push && !do_pop)
			count_next = count + 1'b1;
		else if (do_pop && !do_push)
			count_next = count - 1'b1;
	end

	always_ff @(posedge clock)
	begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			full <= 1'b0;
			empty <= 1'b1;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1; // wraps at depth
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count_next;
			full <= (count_next == bt_pkg::FIFO_FULL);
			empty <= (count_next == '0);
		end
	end

	// producer and consumer must respect the flags
	a_no_overflow: assert property (@(posedge clock) disable iff (!resetn) !(push && full))
		else $error("word_fifo: push while full, word dropped");
	a_no_underflow: assert property (@(posedge clock) disable iff (!resetn) !(pop && empty))
		else $error("word_fifo: pop while empty");
endmodule

//--- run.sh
#!/bin/sh
# build and run the bridge testbench with Verilator, pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module bt_bridge_tb \
	-f verilog.f -o bt_bridge_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/bt_bridge_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q '^>>> PASS$' sim.log; then
	exit 0
fi
echo "pass line not found in sim.log"
exit 1

//--- tests/bt_bridge_tb.sv
// bridge testbench with an HC-05 line model. the response FIFO holds 16 words, so replies stay short
module bt_bridge_tb;
	localparam int NUM_TESTS = 6;
	localparam int LIMIT = NUM_TESTS * (bt_pkg::FIFO_DEPTH * 80 * 2 + 2000);

	logic clock;
	logic resetn;
	logic bt_state;
	logic rxd;
	bt_pkg::word_t wire_in;
	bt_pkg::word_t trig_in;
	logic bt_enable;
	logic txd;
	bt_pkg::status_t status_out;
	bt_pkg::word_t response_out;

	int errors;
	int failed_tests;
	int cycles;
	logic [31:0] lcg_state;
	bt_pkg::word_t ramp_model; // ramp value the sensor should show next
	bt_pkg::word_t tx_words[$]; // words decoded from txd

	// ########################################
	// scenario table
	logic          tab_at_mode [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
	bt_pkg::sel_t  tab_select [NUM_TESTS] = '{2'd0, 2'd3, 2'd1, 2'd2, 2'd0, 2'd0};
	int            tab_n_at [NUM_TESTS] = '{0, 0, 0, 0, 4, 1};
	bt_pkg::word_t tab_at_words [NUM_TESTS][4] = '{'{16'h0, 16'h0, 16'h0, 16'h0},
		'{16'h0, 16'h0, 16'h0, 16'h0}, '{16'h0, 16'h0, 16'h0, 16'h0},
		'{16'h0, 16'h0, 16'h0, 16'h0}, '{16'h4154, 16'h2B4E, 16'h414D, 16'h453F},
		'{16'h4154, 16'h0, 16'h0, 16'h0}};
	int            tab_n_resp [NUM_TESTS] = '{0, 0, 0, 0, 4, 6};
	logic          tab_resp_rand [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
	bt_pkg::word_t tab_resp_words [NUM_TESTS][4] = '{'{16'h0, 16'h0, 16'h0, 16'h0},
		'{16'h0, 16'h0, 16'h0, 16'h0}, '{16'h0, 16'h0, 16'h0, 16'h0},
		'{16'h0, 16'h0, 16'h0, 16'h0}, '{16'h2B4E, 16'h414D, 16'h453A, 16'h4843},
		'{16'h0, 16'h0, 16'h0, 16'h0}};
	string         tab_name [NUM_TESTS] = '{"data ramp", "data inverted ramp",
		"data const A", "data const B", "AT fixed reply", "AT random reply"};

	clock_gen clk_gen (.clock(clock), .resetn(resetn));

	bt_bridge UUT (.clock(clock), .resetn(resetn), .bt_state(bt_state), .rxd(rxd),
		.wire_in(wire_in), .trig_in(trig_in), .bt_enable(bt_enable), .txd(txd),
		.status_out(status_out), .response_out(response_out));

	// ########################################
	// compare tasks and reference rules
	task automatic check_word(input bt_pkg::word_t got, input bt_pkg::word_t exp,
		input string what);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_status(input bt_pkg::status_t got, input bt_pkg::status_t exp,
		input string what);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t: %s, got %b expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t: %s, got %b expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	function automatic bt_pkg::status_t expected_status(input logic resp_empty,
		input bt_pkg::seq_state_t st, input logic rx_done, input logic tx_done, input logic bt);
		bt_pkg::status_t s;
		s = '0;
		s[0] = bt;
		s[1] = tx_done;
		s[2] = rx_done;
		s[5:3] = st;
		s[6] = resp_empty;
		return s;
	endfunction

	function automatic bt_pkg::word_t expected_sensor_word(input bt_pkg::sel_t sel,
		input bt_pkg::word_t ramp);
		case (sel)
			2'd0: return ramp;
			2'd1: return bt_pkg::SENSOR_CONST_A;
			2'd2: return bt_pkg::SENSOR_CONST_B;
			default: return ~ramp;
		endcase
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// ########################################
	// host side helpers driving 5 after the edge
	task automatic step();
		@(posedge clock);
		#5;
	endtask

	task automatic wait_state(input bt_pkg::seq_state_t st);
		while (status_out[5:3] != st)
			step();
	endtask

	task automatic strobe_word(input bt_pkg::word_t w);
		wire_in = w;
		trig_in[bt_pkg::TRG_WORD_STROBE] = 1'b1;
		step();
		trig_in[bt_pkg::TRG_WORD_STROBE] = 1'b0;
		step();
	endtask

	task automatic pop_word();
		trig_in[bt_pkg::TRG_POP] = 1'b1;
		step();
		trig_in[bt_pkg::TRG_POP] = 1'b0;
		step();
	endtask

	// ########################################
	// HC-05 line model
	task automatic play_byte(input bt_pkg::byte_t b);
		rxd = 1'b0; // start bit
		repeat (bt_pkg::CLKS_PER_BIT) step();
		for (int i = 0; i < 8; i++)
		begin
			rxd = b[i];
			repeat (bt_pkg::CLKS_PER_BIT) step();
		end
		rxd = 1'b1;
		repeat (bt_pkg::CLKS_PER_BIT) step();
	endtask

	task automatic play_word(input bt_pkg::word_t w);
		play_byte(w[7:0]);
		play_byte(w[15:8]);
	endtask

	// samples on falling edges near mid-bit
	task automatic read_byte(output bt_pkg::byte_t b, output logic ok);
		@(negedge clock);
		while (txd !== 1'b0)
			@(negedge clock);
		@(negedge clock);
		ok = (txd === 1'b0);
		for (int i = 0; i < 8; i++)
		begin
			repeat (bt_pkg::CLKS_PER_BIT) @(negedge clock);
			b[i] = txd;
		end
		repeat (bt_pkg::CLKS_PER_BIT) @(negedge clock);
		ok = ok && (txd === 1'b1); // stop bit
	endtask

	initial
	begin : txd_decoder
		bt_pkg::byte_t lo;
		bt_pkg::byte_t hi;
		logic ok_lo;
		logic ok_hi;
		forever
		begin
			read_byte(lo, ok_lo);
			read_byte(hi, ok_hi);
			if (ok_lo && ok_hi)
				tx_words.push_back({hi, lo});
			else
			begin
				$display("HC-05 model saw a broken UART frame on txd at time %0t", $time);
				errors++;
			end
		end
	end

	// ########################################
	// scenarios
	task automatic run_data(input int t);
		trig_in = '0;
		trig_in[bt_pkg::TRG_USER_READY] = 1'b1;
		trig_in[bt_pkg::TRG_SELECT_LO +: 2] = tab_select[t];
		wait_state(bt_pkg::COMPLETE);
		repeat (4) step();
		check_word(bt_pkg::word_t'(tx_words.size()), bt_pkg::word_t'(bt_pkg::FIFO_DEPTH),
			"data word count");
		for (int i = 0; i < bt_pkg::FIFO_DEPTH && i < tx_words.size(); i++)
			check_word(tx_words[i],
				expected_sensor_word(tab_select[t], bt_pkg::word_t'(ramp_model + i)),
				"data word on txd");
		ramp_model = bt_pkg::word_t'(ramp_model + bt_pkg::FIFO_DEPTH); // every take moves the ramp
		check_status(status_out, expected_status(1'b1, bt_pkg::COMPLETE, 1'b0, 1'b1, bt_state),
			"status after data run");
	endtask

	task automatic run_at(input int t);
		bt_pkg::word_t exp_tx[$];
		bt_pkg::word_t exp_rx[$];
		bt_pkg::word_t w;
		trig_in = '0;
		trig_in[bt_pkg::TRG_WANT_AT] = 1'b1;
		trig_in[bt_pkg::TRG_USER_READY] = 1'b1;
		step();
		check_bit(bt_enable, 1'b1, "bt_enable with want_at");
		wait_state(bt_pkg::LOAD);
		for (int i = 0; i < tab_n_at[t]; i++)
			exp_tx.push_back(tab_at_words[t][i]);
		exp_tx.push_back(bt_pkg::AT_END);
		foreach (exp_tx[i])
			strobe_word(exp_tx[i]);
		strobe_word(16'hBEEF); // past the terminator
		wait_state(bt_pkg::RECEIVE);
		repeat (4) step();
		check_word(bt_pkg::word_t'(tx_words.size()), bt_pkg::word_t'(exp_tx.size()),
			"AT word count");
		for (int i = 0; i < exp_tx.size() && i < tx_words.size(); i++)
			check_word(tx_words[i], exp_tx[i], "AT word on txd");

		for (int i = 0; i < tab_n_resp[t]; i++)
		begin
			if (tab_resp_rand[t])
			begin
				lcg_state = lcg_next(lcg_state);
				w = lcg_state[31:16];
				if (w == bt_pkg::AT_END)
					w = ~w; // must not end the reply early
			end
			else
				w = tab_resp_words[t][i];
			exp_rx.push_back(w);
		end
		exp_rx.push_back(bt_pkg::AT_END);
		foreach (exp_rx[i])
			play_word(exp_rx[i]);
		wait_state(bt_pkg::COMPLETE);
		check_status(status_out, expected_status(1'b0, bt_pkg::COMPLETE, 1'b1, 1'b1, bt_state),
			"status after reply");
		foreach (exp_rx[i])
		begin
			check_word(response_out, exp_rx[i], "response word");
			pop_word();
		end
		check_status(status_out, expected_status(1'b1, bt_pkg::COMPLETE, 1'b1, 1'b1, bt_state),
			"status after popping reply");
	endtask

	task automatic return_to_idle();
		trig_in = '0;
		step();
		check_bit(bt_enable, 1'b0, "bt_enable after want_at drops");
		repeat (2) step();
		check_status(status_out, expected_status(1'b1, bt_pkg::IDLE, 1'b0, 1'b0, bt_state),
			"status back in IDLE");
	endtask

	initial
	begin : watchdog
		cycles = 0;
		while (cycles < LIMIT)
		begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", LIMIT);
		$display(">>> FAIL");
		$finish;
	end

	initial
	begin : main_seq
		int first_err;
		trig_in = '0;
		wire_in = '0;
		rxd = 1'b1;
		bt_state = 1'b0;
		errors = 0;
		failed_tests = 0;
		lcg_state = 32'h3563;
		ramp_model = '0;
		wait (resetn === 1'b1);
		step();
		check_bit(txd, 1'b1, "txd idle after reset");
		check_bit(bt_enable, 1'b0, "bt_enable after reset");
		check_status(status_out, expected_status(1'b1, bt_pkg::IDLE, 1'b0, 1'b0, 1'b0),
			"status after reset");

		for (int t = 0; t < NUM_TESTS; t++)
		begin
			first_err = errors;
			tx_words.delete();
			bt_state = t[0]; // mirrored in status bit 0
			step();
			if (tab_at_mode[t])
				run_at(t);
			else
				run_data(t);
			return_to_idle();
			if (errors != first_err)
				failed_tests++;
			$display("test %0d %s: %s", t, tab_name[t], (errors == first_err) ? "ok" : "failed");
		end

		$display("%0d tests run, %0d failed, %0d check errors", NUM_TESTS, failed_tests, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end
endmodule

//--- tests/clock_gen.sv
// free running clock of period 40 with resetn held low for the first two cycles
module clock_gen (
	output logic clock,
	output logic resetn
);
	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	initial
	begin
		resetn = 1'b0;
		repeat (2) @(posedge clock);
		#5 resetn = 1'b1; // release away from the edge
	end
endmodule

//--- verilog.f
rtl/bt_pkg.sv
rtl/test_sensor.sv
rtl/word_fifo.sv
rtl/serial_tx16.sv
rtl/serial_rx16.sv
rtl/link_sequencer.sv
rtl/bt_bridge.sv
tests/clock_gen.sv
tests/bt_bridge_tb.sv
